//--- list.f
apb_subsystem_pkg.sv
ahb2apb_bridge.sv
apb_gpio.sv
apb_uart_tx.sv
apb_subsystem.sv
tb_apb_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the APB subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --top-module tb_apb_subsystem -f list.f -o Vtb_apb_subsystem
./obj_dir/Vtb_apb_subsystem > sim.log
cat sim.log
if grep -q "^TESTS PASSED$" sim.log; then
  echo "Simulation run passed"
else
  echo "Simulation run failed"
  exit 1
fi

//--- tb_apb_subsystem.sv
// APB subsystem testbench, AHB driver, reference model and UART monitor
// Random GPIO, UART and bridge traffic from an xorshift generator

`timescale 1ns/1ps

module tb_apb_subsystem;

  localparam int GPIO_WIDTH = 16;
  localparam int CLK_NS     = 10;
  localparam int N_XFER     = 400;  // Upper bound on transfers, status polls included
  localparam int N_FRAME    = 6;
  localparam int MAX_DIV    = 20;
  localparam int WDOG_CYC   = 2 * (N_XFER * 3 + N_FRAME * 10 * MAX_DIV);
  localparam logic [31:0] A_UART_TX   = 32'(apb_subsystem_pkg::UART_TXDATA);
  localparam logic [31:0] A_UART_STAT = 32'(apb_subsystem_pkg::UART_STATUS);
  localparam logic [31:0] A_UART_DIV  = 32'(apb_subsystem_pkg::UART_BAUD_DIV);
  localparam logic [31:0] A_GPIO_OUT  = 32'h2000 | 32'(apb_subsystem_pkg::GPIO_DATA_OUT);
  localparam logic [31:0] A_GPIO_DIR  = 32'h2000 | 32'(apb_subsystem_pkg::GPIO_DIR);
  localparam logic [31:0] A_GPIO_IN   = 32'h2000 | 32'(apb_subsystem_pkg::GPIO_DATA_IN);

  logic tb_hclk17;
  logic hresetn17;
  apb_subsystem_pkg::ahb_req_t ahb;
  logic [31:0] hwdata, hrdata, rd, seed;
  logic hready, ua_ncts, ua_txd;
  logic [1:0] hresp;
  logic [GPIO_WIDTH-1:0] pin_in, pin_out, n_pin_oe;
  logic [GPIO_WIDTH-1:0] model_out, model_dir;  // Expected GPIO registers
  logic [7:0] model_byte;                      // Byte the UART should send
  logic model_busy;
  logic [3:0] slot;
  logic [7:0] rx_q[$];                         // Bytes rebuilt by the monitor
  int model_div, errors, tests, base;

  apb_subsystem #(.GPIO_WIDTH(GPIO_WIDTH), .UART_DEFAULT_DIV(16'd16)) u_apb_subsystem (
    .tb_hclk17(tb_hclk17), .hresetn17(hresetn17), .i_ahb(ahb), .i_hwdata(hwdata),
    .i_ua_ncts(ua_ncts), .i_gpio_pin_in(pin_in), .o_hrdata(hrdata), .o_hready(hready),
    .o_hresp(hresp), .o_ua_txd(ua_txd), .o_gpio_pin_out(pin_out),
    .o_n_gpio_pin_oe(n_pin_oe)
  );

  initial begin
    tb_hclk17 = 1'b0;
    forever #(CLK_NS / 2) tb_hclk17 = ~tb_hclk17;
  end

  initial begin
    #(WDOG_CYC * CLK_NS);
    $display("Watchdog expired after %0d cycles, run stopped", WDOG_CYC);
    $display("TESTS FAILED");
    $finish;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
    $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
    errors++;
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("%s: %s, %0d errors", name, (errors == base) ? "ok" : "failed", errors - base);
    base = errors;
  endtask

  // ==========================================================================
  // AHB single transfer, returns in the cycle HREADY is back high
  // ==========================================================================

  task automatic ahb_xfer(input logic [31:0] addr, input logic wr, input logic [31:0] wdata,
                          output logic [31:0] rdata);
    int low_cycles;
    low_cycles = 0;
    ahb.haddr     = addr;                         // Address phase
    ahb.htrans    = apb_subsystem_pkg::HTRANS_NONSEQ;
    ahb.hsize     = 3'b010;                       // Word
    ahb.hwrite    = wr;
    ahb.hsel      = 1'b1;
    ahb.hready_in = 1'b1;
    @(posedge tb_hclk17);
    #1;
    ahb.htrans = apb_subsystem_pkg::HTRANS_IDLE;
    ahb.hsel   = 1'b0;
    hwdata     = wdata;                           // Data phase
    while (!hready && low_cycles < 8) begin      // Bounded wait on HREADY
      low_cycles++;
      @(posedge tb_hclk17);
      #1;
    end
    if (low_cycles != 2)
      mismatch("HREADY low cycle count", 32'(low_cycles), 32'd2);
    if (hresp !== apb_subsystem_pkg::HRESP_OKAY)
      mismatch("HRESP", 32'(hresp), 32'(apb_subsystem_pkg::HRESP_OKAY));
    rdata = hrdata;
  endtask

  // TXDATA write, model drops it while busy
  task automatic uart_send(input logic [7:0] b);
    logic [31:0] unused_rd;
    ahb_xfer(A_UART_TX, 1'b1, {24'h0, b}, unused_rd);
    if (!model_busy) begin
      model_busy = 1'b1;
      model_byte = b;
    end
  endtask

  task automatic wait_uart_idle();
    logic [31:0] st;
    int polls;
    polls = 0;
    st = 32'h1;
    while (st[0] && polls < 100) begin   // Longest frame is 200 cycles
      ahb_xfer(A_UART_STAT, 1'b0, 32'h0, st);
      polls++;
    end
    if (st[0]) begin
      $display("UART busy did not clear after %0d status reads", polls);
      errors++;
    end
    model_busy = 1'b0;
  endtask

  task automatic check_rx();
    if (rx_q.size() != 1) begin
      $display("UART monitor holds %0d bytes where one was expected", rx_q.size());
      errors++;
    end else if (rx_q[0] !== model_byte) begin
      mismatch("UART frame byte", 32'(rx_q[0]), 32'(model_byte));
    end
    rx_q.delete();
  endtask

  // UART monitor, samples mid-bit with the model divisor
  initial begin : uart_monitor
    int div;
    logic [7:0] b;
    wait (hresetn17 === 1'b1);
    forever begin
      @(negedge ua_txd);
      div = model_div;
      repeat (div / 2) @(posedge tb_hclk17);
      #1;
      if (ua_txd !== 1'b0)
        mismatch("UART start bit", 32'(ua_txd), 32'h0);
      for (int i = 0; i < 8; i++) begin    // LSB first
        repeat (div) @(posedge tb_hclk17);
        #1;
        b[i] = ua_txd;
      end
      repeat (div) @(posedge tb_hclk17);
      #1;
      if (ua_txd !== 1'b1)
        mismatch("UART stop bit", 32'(ua_txd), 32'h1);
      rx_q.push_back(b);
    end
  end

  // ==========================================================================
  // Test sequence
  // ==========================================================================

  initial begin
    ahb = '0;
    hwdata = 32'h0;
    ua_ncts = 1'b1;
    pin_in = '0;
    hresetn17 = 1'b0;
    seed = 32'h8fcb_d73d;
    model_out = '0;
    model_dir = '0;
    model_div = 16;                // Reset divisor
    model_busy = 1'b0;
    model_byte = 8'h0;
    errors = 0;
    tests = 0;
    base = 0;
    repeat (4) @(posedge tb_hclk17);
    #1;
    hresetn17 = 1'b1;

    // Idle bus, idle line, all pins inputs
    if (hready !== 1'b1)
      mismatch("HREADY after reset", 32'(hready), 32'h1);
    if (hresp !== apb_subsystem_pkg::HRESP_OKAY)
      mismatch("HRESP after reset", 32'(hresp), 32'(apb_subsystem_pkg::HRESP_OKAY));
    if (ua_txd !== 1'b1)
      mismatch("UART TXD after reset", 32'(ua_txd), 32'h1);
    if (pin_out !== '0)
      mismatch("GPIO pin out after reset", 32'(pin_out), 32'h0);
    if (n_pin_oe !== '1)
      mismatch("GPIO output enable after reset", 32'(n_pin_oe), 32'(16'hffff));
    ahb_xfer(A_UART_STAT, 1'b0, 32'h0, rd);
    if (rd !== 32'h0)
      mismatch("UART STATUS after reset", rd, 32'h0);
    ahb_xfer(A_UART_DIV, 1'b0, 32'h0, rd);
    if (rd !== 32'(model_div))
      mismatch("UART BAUD_DIV after reset", rd, 32'(model_div));
    finish_test("reset state");

    for (int i = 0; i < 8; i++) begin  // GPIO read-back, upper data bits random
      seed = xorshift(seed);
      model_out = seed[GPIO_WIDTH-1:0];
      ahb_xfer(A_GPIO_OUT, 1'b1, seed, rd);
      if (pin_out !== model_out)
        mismatch("GPIO pin out", 32'(pin_out), 32'(model_out));
      seed = xorshift(seed);
      model_dir = seed[GPIO_WIDTH-1:0];
      ahb_xfer(A_GPIO_DIR, 1'b1, seed, rd);
      if (n_pin_oe !== ~model_dir)
        mismatch("GPIO output enable", 32'(n_pin_oe), 32'(~model_dir));
      ahb_xfer(A_GPIO_OUT, 1'b0, 32'h0, rd);
      if (rd !== 32'(model_out))
        mismatch("GPIO DATA_OUT read", rd, 32'(model_out));
      ahb_xfer(A_GPIO_DIR, 1'b0, 32'h0, rd);
      if (rd !== 32'(model_dir))
        mismatch("GPIO DIR read", rd, 32'(model_dir));
    end
    finish_test("gpio register read-back");

    for (int i = 0; i < 8; i++) begin  // Pins held 2 cycles through the synchronizer
      seed = xorshift(seed);
      pin_in = seed[GPIO_WIDTH-1:0];
      repeat (2) @(posedge tb_hclk17);
      #1;
      ahb_xfer(A_GPIO_IN, 1'b0, 32'h0, rd);
      if (rd !== 32'(pin_in))
        mismatch("GPIO DATA_IN read", rd, 32'(pin_in));
    end
    finish_test("gpio input sampling");

    ua_ncts = 1'b0;
    for (int i = 0; i < 4; i++) begin
      seed = xorshift(seed);
      model_div = 4 + seed[31:8] % 17;   // 4 to 20
      ahb_xfer(A_UART_DIV, 1'b1, 32'(model_div), rd);
      ahb_xfer(A_UART_DIV, 1'b0, 32'h0, rd);
      if (rd !== 32'(model_div))
        mismatch("UART BAUD_DIV read", rd, 32'(model_div));
      uart_send(seed[7:0]);
      ahb_xfer(A_UART_STAT, 1'b0, 32'h0, rd);
      if (rd !== 32'(model_busy))
        mismatch("UART STATUS during frame", rd, 32'(model_busy));
      wait_uart_idle();
      check_rx();
    end
    finish_test("uart frames");

    ua_ncts = 1'b1;                    // Not clear to send
    seed = xorshift(seed);
    uart_send(seed[7:0]);
    repeat (3 * model_div) begin
      @(posedge tb_hclk17);
      #1;
      if (ua_txd !== 1'b1)
        mismatch("UART TXD with CTS high", 32'(ua_txd), 32'h1);
    end
    ahb_xfer(A_UART_STAT, 1'b0, 32'h0, rd);
    if (rd !== 32'(model_busy))
      mismatch("UART STATUS with CTS high", rd, 32'(model_busy));
    uart_send(~model_byte);            // Dropped, UART busy
    ua_ncts = 1'b0;
    wait_uart_idle();
    check_rx();
    finish_test("uart clear-to-send and busy");

    for (int i = 0; i < 6; i++) begin  // Back-to-back across slots
      seed = xorshift(seed);
      slot = seed[15:12];
      if (slot == apb_subsystem_pkg::SLOT_UART || slot == apb_subsystem_pkg::SLOT_GPIO)
        slot = 4'd5;
      ahb_xfer({16'h0, slot, seed[11:2], 2'b00}, 1'b0, 32'h0, rd);
      if (rd !== 32'h0)
        mismatch("unmapped slot read", rd, 32'h0);
      ahb_xfer(A_GPIO_DIR, 1'b0, 32'h0, rd);
      if (rd !== 32'(model_dir))
        mismatch("GPIO DIR read", rd, 32'(model_dir));
      ahb_xfer(A_UART_DIV, 1'b0, 32'h0, rd);
      if (rd !== 32'(model_div))
        mismatch("UART BAUD_DIV read", rd, 32'(model_div));
      ahb_xfer({16'h0, slot, 12'h000}, 1'b1, seed, rd);   // Goes nowhere
      ahb_xfer(A_GPIO_OUT, 1'b0, 32'h0, rd);
      if (rd !== 32'(model_out))
        mismatch("GPIO DATA_OUT read", rd, 32'(model_out));
    end
    finish_test("bridge protocol");

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- apb_subsystem.sv
// APB subsystem top, AHB bridge with UART transmitter and GPIO behind it

`timescale 1ns/1ps

module apb_subsystem #(
  parameter int          GPIO_WIDTH       = 16,
  parameter logic [15:0] UART_DEFAULT_DIV = 16'd16
) (
  input  logic                        tb_hclk17,
  input  logic                        hresetn17,        // Sync, active low
  input  apb_subsystem_pkg::ahb_req_t i_ahb,
  input  logic [31:0]                 i_hwdata,
  input  logic                        i_ua_ncts,
  input  logic [GPIO_WIDTH-1:0]       i_gpio_pin_in,
  output logic [31:0]                 o_hrdata,
  output logic                        o_hready,
  output logic [1:0]                  o_hresp,
  output logic                        o_ua_txd,
  output logic [GPIO_WIDTH-1:0]       o_gpio_pin_out,
  output logic [GPIO_WIDTH-1:0]       o_n_gpio_pin_oe
);

  // ==========================================================================
  // APB fabric
  // ==========================================================================

  apb_subsystem_pkg::apb_req_t apb;      // Shared request
  logic                        psel_uart;
  logic                        psel_gpio;
  logic [31:0]                 prdata_uart;
  logic [31:0]                 prdata_gpio;

  ahb2apb_bridge u_ahb2apb_bridge (
    .i_clk         (tb_hclk17),
    .i_rst_n       (hresetn17),
    .i_ahb         (i_ahb),
    .i_hwdata      (i_hwdata),
    .i_prdata_uart (prdata_uart),
    .i_prdata_gpio (prdata_gpio),
    .o_hrdata      (o_hrdata),
    .o_hready      (o_hready),
    .o_hresp       (o_hresp),
    .o_apb         (apb),
    .o_psel_uart   (psel_uart),
    .o_psel_gpio   (psel_gpio)
  );

  apb_uart_tx #(.UART_DEFAULT_DIV(UART_DEFAULT_DIV)) u_apb_uart_tx (
    .i_clk     (tb_hclk17),
    .i_rst_n   (hresetn17),
    .i_apb     (apb),
    .i_psel    (psel_uart),
    .i_ua_ncts (i_ua_ncts),
    .o_prdata  (prdata_uart),
    .o_ua_txd  (o_ua_txd)
  );

  apb_gpio #(.GPIO_WIDTH(GPIO_WIDTH)) u_apb_gpio (
    .i_clk           (tb_hclk17),
    .i_rst_n         (hresetn17),
    .i_apb           (apb),
    .i_psel          (psel_gpio),
    .i_gpio_pin_in   (i_gpio_pin_in),
    .o_prdata        (prdata_gpio),
    .o_gpio_pin_out  (o_gpio_pin_out),
    .o_n_gpio_pin_oe (o_n_gpio_pin_oe)
  );

endmodule

//--- apb_uart_tx.sv
// APB UART transmitter, 8N1 frames with programmable bit divisor
// Clear-to-send low lets a pending byte go out

`timescale 1ns/1ps

module apb_uart_tx #(
  parameter logic [15:0] UART_DEFAULT_DIV = 16'd16
) (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  apb_subsystem_pkg::apb_req_t i_apb,
  input  logic                        i_psel,
  input  logic                        i_ua_ncts,     // Clear to send, active low
  output logic [31:0]                 o_prdata,
  output logic                        o_ua_txd
);

  logic [15:0] baud_div_q;   // Programmed divisor
  logic [15:0] div_act_q;    // Divisor of the frame on the wire
  logic [15:0] cnt_q;        // Cycles within current bit
  logic [3:0]  bit_idx_q;    // 0 start, 1..8 data, 9 stop
  logic [9:0]  frame_q;      // {stop, data, start}
  logic        busy_q;       // Byte pending or being sent
  logic        sending_q;    // Frame on the wire
  logic        wr_en;
  logic        bit_end;

  assign wr_en   = i_psel && i_apb.penable && i_apb.pwrite;
  assign bit_end = (cnt_q == div_act_q - 16'd1);

  // ==========================================================================
  // Register writes
  // ==========================================================================

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      baud_div_q <= UART_DEFAULT_DIV;
    end else if (wr_en && i_apb.paddr == apb_subsystem_pkg::UART_BAUD_DIV) begin
      baud_div_q <= i_apb.pwdata[15:0];   // Used from the next frame
    end
  end

  // Byte latch, only while idle
  always_ff @(posedge i_clk) begin
    if (wr_en && !busy_q && i_apb.paddr == apb_subsystem_pkg::UART_TXDATA) begin
      frame_q <= {1'b1, i_apb.pwdata[7:0], 1'b0};
    end
  end

  // ==========================================================================
  // Transmit sequencer
  // ==========================================================================

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      busy_q    <= 1'b0;
      sending_q <= 1'b0;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      div_act_q <= UART_DEFAULT_DIV;
    end else if (!busy_q) begin
      // Writes while busy are dropped
      if (wr_en && i_apb.paddr == apb_subsystem_pkg::UART_TXDATA) begin
        busy_q <= 1'b1;
      end
    end else if (!sending_q) begin
      if (!i_ua_ncts) begin               // Start bit from this edge
        sending_q <= 1'b1;
        cnt_q     <= '0;
        bit_idx_q <= '0;
        div_act_q <= baud_div_q;          // Freeze divisor for the frame
      end
    end else if (bit_end) begin
      cnt_q <= '0;
      if (bit_idx_q == 4'd9) begin        // Stop bit done
        sending_q <= 1'b0;
        busy_q    <= 1'b0;
      end else begin
        bit_idx_q <= bit_idx_q + 4'd1;
      end
    end else begin
      cnt_q <= cnt_q + 16'd1;
    end
  end

  assign o_ua_txd = sending_q ? frame_q[bit_idx_q] : 1'b1;   // Line idles high

  // Read back
  always_comb begin
    case (i_apb.paddr)
      apb_subsystem_pkg::UART_STATUS:   o_prdata = {31'h0, busy_q};
      apb_subsystem_pkg::UART_BAUD_DIV: o_prdata = {16'h0, baud_div_q};
      default:                          o_prdata = 32'h0;   // TXDATA write only
    endcase
  end

endmodule

//--- apb_gpio.sv
// APB GPIO with output data, direction and synchronized input registers

`timescale 1ns/1ps

module apb_gpio #(
  parameter int GPIO_WIDTH = 16
) (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  apb_subsystem_pkg::apb_req_t i_apb,
  input  logic                        i_psel,
  input  logic [GPIO_WIDTH-1:0]       i_gpio_pin_in,
  output logic [31:0]                 o_prdata,
  output logic [GPIO_WIDTH-1:0]       o_gpio_pin_out,
  output logic [GPIO_WIDTH-1:0]       o_n_gpio_pin_oe
);

  logic [GPIO_WIDTH-1:0] data_out_q;
  logic [GPIO_WIDTH-1:0] dir_q;        // 1 = output
  logic [GPIO_WIDTH-1:0] sync1_q;      // First sync stage
  logic [GPIO_WIDTH-1:0] sync2_q;      // Backs DATA_IN
  logic                  wr_en;

  assign wr_en = i_psel && i_apb.penable && i_apb.pwrite;  // Access cycle write

  // Control registers
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      data_out_q <= '0;
      dir_q      <= '0;        // All pins inputs
    end else if (wr_en) begin
      case (i_apb.paddr)
        apb_subsystem_pkg::GPIO_DATA_OUT: data_out_q <= i_apb.pwdata[GPIO_WIDTH-1:0];
        apb_subsystem_pkg::GPIO_DIR:      dir_q      <= i_apb.pwdata[GPIO_WIDTH-1:0];
        default: ;                                 // DATA_IN read only
      endcase
    end
  end

  // Two-flop synchronizer on the pins
  always_ff @(posedge i_clk) begin
    sync1_q <= i_gpio_pin_in;
    sync2_q <= sync1_q;
  end

  // Pin drivers
  assign o_gpio_pin_out  = data_out_q;
  assign o_n_gpio_pin_oe = ~dir_q;    // Active low enable

  // Read back, zero extended
  always_comb begin
    case (i_apb.paddr)
      apb_subsystem_pkg::GPIO_DATA_OUT: o_prdata = 32'(data_out_q);
      apb_subsystem_pkg::GPIO_DIR:      o_prdata = 32'(dir_q);
      apb_subsystem_pkg::GPIO_DATA_IN:  o_prdata = 32'(sync2_q);
      default:                          o_prdata = 32'h0;
    endcase
  end

endmodule

//--- ahb2apb_bridge.sv
// AHB-Lite to APB bridge, one 4 KB slot per peripheral
// Runs setup and access phases and returns registered read data

`timescale 1ns/1ps

module ahb2apb_bridge (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  apb_subsystem_pkg::ahb_req_t i_ahb,         // Address phase
  input  logic [31:0]                 i_hwdata,      // Data phase write data
  input  logic [31:0]                 i_prdata_uart,
  input  logic [31:0]                 i_prdata_gpio,
  output logic [31:0]                 o_hrdata,
  output logic                        o_hready,
  output logic [1:0]                  o_hresp,
  output apb_subsystem_pkg::apb_req_t o_apb,
  output logic                        o_psel_uart,
  output logic                        o_psel_gpio
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } state_t;

  state_t      state_q;
  logic        accept;
  logic [11:0] addr_q;      // Offset within slot
  logic [3:0]  slot_q;      // Slot latched at acceptance
  logic        write_q;
  logic [31:0] pwdata_q;    // Write data held through access
  logic [31:0] hrdata_q;
  logic [31:0] prdata_mux;

  // ==========================================================================
  // Address phase acceptance
  // ==========================================================================

  // Only NONSEQ and SEQ start work, bursts run as singles
  assign accept = i_ahb.hsel && i_ahb.hready_in && o_hready &&
                  (i_ahb.htrans == apb_subsystem_pkg::HTRANS_NONSEQ ||
                   i_ahb.htrans == apb_subsystem_pkg::HTRANS_SEQ);

  // Sequencer
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE:   if (accept) state_q <= ST_SETUP;
        ST_SETUP:  state_q <= ST_ACCESS;   // No wait states on APB
        ST_ACCESS: state_q <= ST_IDLE;
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  // Address, direction and slot captured with the transfer
  always_ff @(posedge i_clk) begin
    if (accept) begin
      addr_q  <= i_ahb.haddr[11:0];
      slot_q  <= i_ahb.haddr[15:12];
      write_q <= i_ahb.hwrite;
    end
  end

  // hwdata valid from the first data cycle, hold it for access
  always_ff @(posedge i_clk) begin
    if (state_q == ST_SETUP) begin
      pwdata_q <= i_hwdata;
    end
  end

  // ==========================================================================
  // APB side
  // ==========================================================================

  assign o_psel_uart = (state_q != ST_IDLE) && (slot_q == apb_subsystem_pkg::SLOT_UART);
  assign o_psel_gpio = (state_q != ST_IDLE) && (slot_q == apb_subsystem_pkg::SLOT_GPIO);

  always_comb begin
    o_apb.paddr   = addr_q;
    o_apb.pwrite  = write_q;
    o_apb.penable = (state_q == ST_ACCESS);
    // Setup cycle sees hwdata directly, access the held copy
    o_apb.pwdata  = (state_q == ST_SETUP) ? i_hwdata : pwdata_q;
  end

  // Read data by latched slot, unmapped slots read zero
  always_comb begin
    case (slot_q)
      apb_subsystem_pkg::SLOT_UART: prdata_mux = i_prdata_uart;
      apb_subsystem_pkg::SLOT_GPIO: prdata_mux = i_prdata_gpio;
      default:                      prdata_mux = 32'h0;
    endcase
  end

  // Registered at the end of access
  always_ff @(posedge i_clk) begin
    if (state_q == ST_ACCESS && !write_q) begin
      hrdata_q <= prdata_mux;
    end
  end

  // ==========================================================================
  // AHB response
  // ==========================================================================

  assign o_hready = (state_q == ST_IDLE);   // Low through setup and access
  assign o_hrdata = hrdata_q;
  assign o_hresp  = apb_subsystem_pkg::HRESP_OKAY;

endmodule

//--- apb_subsystem_pkg.sv
// APB subsystem shared types, address map and register offsets
// AHB request bundle, APB request and peripheral register map

package apb_subsystem_pkg;

  // ==========================================================================
  // Bus bundles
  // ==========================================================================

  // AHB address phase, write data follows one phase later
  typedef struct packed {
    logic [31:0] haddr;
    logic [1:0]  htrans;
    logic [2:0]  hsize;      // Byte, half or word
    logic        hwrite;
    logic        hsel;
    logic        hready_in;  // Previous transfer done on the bus
  } ahb_req_t;

  // APB request, common to every slave
  typedef struct packed {
    logic [11:0] paddr;      // Offset inside a 4 KB slot
    logic        pwrite;
    logic        penable;
    logic [31:0] pwdata;
  } apb_req_t;

  // ==========================================================================
  // Encodings
  // ==========================================================================

  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  localparam logic [1:0] HRESP_OKAY    = 2'b00;  // Only response given

  // Slot numbers, haddr[15:12]
  localparam logic [3:0] SLOT_UART     = 4'd0;
  localparam logic [3:0] SLOT_GPIO     = 4'd2;

  // UART register offsets
  localparam logic [11:0] UART_TXDATA   = 12'h000;
  localparam logic [11:0] UART_STATUS   = 12'h004;
  localparam logic [11:0] UART_BAUD_DIV = 12'h008;

  // GPIO register offsets
  localparam logic [11:0] GPIO_DATA_OUT = 12'h000;
  localparam logic [11:0] GPIO_DIR      = 12'h004;
  localparam logic [11:0] GPIO_DATA_IN  = 12'h008;

endpackage
